// ==== hdl/controlPkg.sv ====
// Control unit shared definitions
`default_nettype none

package controlPkg;

   localparam int OpcodeWidth = 5;
   localparam int CondWidth   = 3;

   localparam int FlagC = 0;
   localparam int FlagZ = 1;
   localparam int FlagN = 2;
   localparam int FlagV = 3;

   typedef logic [OpcodeWidth+CondWidth-1:0] instrField_t;   // Opcode above condition
   typedef logic [3:0]                       flags_t;

   typedef enum logic [OpcodeWidth-1:0] {
      ADD    = 5'd0,  ADDI  = 5'd1,  ADDIB = 5'd2,  ADC    = 5'd3,
      ADCI   = 5'd4,  SUB   = 5'd5,  SUBI  = 5'd6,  SUBIB  = 5'd7,
      SUC    = 5'd8,  SUCI  = 5'd9,  NEG   = 5'd10, CMP    = 5'd11,
      CMPI   = 5'd12, AND   = 5'd13, OR    = 5'd14, XOR    = 5'd15,
      NOT    = 5'd16, NAND  = 5'd17, NOR   = 5'd18, LSL    = 5'd19,
      LSR    = 5'd20, ASR   = 5'd21, LUI   = 5'd22, LLI    = 5'd23,
      LDW    = 5'd24, STW   = 5'd25, BRANCH = 5'd28
   } opcode_t;

   typedef enum logic [CondWidth-1:0] {
      BR, BNE, BE, BLT, BGE, BWL, RET, JMP
   } branchCode_t;

   typedef enum logic [3:0] {
      FnA, FnADD, FnADC, FnSUB, FnNEG, FnAND, FnOR, FnXOR,
      FnNOT, FnNAND, FnNOR, FnLSL, FnLSR, FnASR, FnLUI, FnLLI
   } aluFunction_t;

   typedef enum logic       {Op1Rd1, Op1Pc}              op1Select_t;
   typedef enum logic [1:0] {Op2Imm, Op2Rd2, Op2Zero}    op2Select_t;
   typedef enum logic       {ImmLong, ImmShort}          immSelect_t;
   typedef enum logic       {Rs1Ra, Rs1Rd}               rs1Select_t;
   typedef enum logic       {RwRd}                       rwSelect_t;
   typedef enum logic       {WdAlu, WdSys}               wdSelect_t;
   typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus}    pcSelect_t;
   typedef enum logic       {LrSys, LrPc}                lrSelect_t;

   typedef enum logic       {Fetch, Execute}                          majorPhase_t;
   typedef enum logic [2:0] {Cycle0, Cycle1, Cycle2, Cycle3, Cycle4} subCycle_t;
   typedef enum logic [1:0] {ClassSingle, ClassLoad, ClassStore}    instrClass_t;

   typedef struct packed {
      aluFunction_t aluOp;
      op1Select_t   op1Sel;
      op2Select_t   op2Sel;
      immSelect_t   immSel;
      rs1Select_t   rs1Sel;
      rwSelect_t    rwSel;
      wdSelect_t    wdSel;
      pcSelect_t    pcSel;
      lrSelect_t    lrSel;
      logic         aluEn;   // ALU result onto sysbus
      logic         aluWe;
      logic         regWe;
      logic         pcWe;
      logic         pcEn;    // PC onto sysbus
      logic         irWe;
      logic         lrEn;
      logic         lrWe;
   } datapathCtrl_t;

   typedef struct packed {
      logic ale;
      logic nMe;
      logic nOe;
      logic nWe;
      logic enb;
      logic memEn;   // Pad direction
   } busCtrl_t;

   // Quiet control word, everything off
   localparam datapathCtrl_t DatapathIdle = '{
      aluOp: FnA, op1Sel: Op1Rd1, op2Sel: Op2Imm, immSel: ImmLong,
      rs1Sel: Rs1Ra, rwSel: RwRd, wdSel: WdAlu, pcSel: Pc1, lrSel: LrSys,
      aluEn: 1'b0, aluWe: 1'b0, regWe: 1'b0, pcWe: 1'b0,
      pcEn: 1'b0, irWe: 1'b0, lrEn: 1'b0, lrWe: 1'b0
   };

   localparam busCtrl_t BusIdle = '{
      ale: 1'b0, nMe: 1'b1, nOe: 1'b0, nWe: 1'b0, enb: 1'b0, memEn: 1'b0
   };

endpackage

`default_nettype wire

// ==== hdl/phaseSequencer.sv ====
// Fetch and execute phase sequencer
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer (
   input  wire                     Clock,
   input  wire                     nReset,
   input  controlPkg::instrClass_t Class,
   input  logic                    nWait,
   output controlPkg::majorPhase_t Phase,
   output controlPkg::subCycle_t   SubCycle
);

   import controlPkg::*;

   majorPhase_t phaseNext;
   subCycle_t   subCycleNext;

   always_comb begin
      phaseNext    = Phase;
      subCycleNext = SubCycle;
      if (Phase == Fetch) begin
         case (SubCycle)
            Cycle0: subCycleNext = Cycle1;
            Cycle1: subCycleNext = Cycle2;
            Cycle2: if (nWait) subCycleNext = Cycle3;   // Instruction read stretch
            default: begin
               phaseNext    = Execute;
               subCycleNext = Cycle0;
            end
         endcase
      end else begin
         case (SubCycle)
            Cycle0: begin
               if (Class == ClassSingle) begin
                  phaseNext = Fetch;                  // Done in one cycle
               end else begin
                  subCycleNext = Cycle1;              // Memory access path
               end
            end
            Cycle1: subCycleNext = Cycle2;
            Cycle2: subCycleNext = Cycle3;
            Cycle3: if (nWait) subCycleNext = Cycle4;   // Data read or write stretch
            default: begin
               phaseNext    = Fetch;
               subCycleNext = Cycle0;
            end
         endcase
      end
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         Phase    <= Fetch;
         SubCycle <= Cycle0;
      end else begin
         Phase    <= phaseNext;
         SubCycle <= subCycleNext;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/instructionDecoder.sv ====
// Datapath control word decoder
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder (
   input  controlPkg::opcode_t       Opcode,
   input  controlPkg::branchCode_t   BranchCode,
   input  controlPkg::majorPhase_t   Phase,
   input  controlPkg::subCycle_t     SubCycle,
   input  logic                      BranchTaken,
   output controlPkg::instrClass_t   Class,
   output logic                      StatusWe,
   output controlPkg::datapathCtrl_t DatapathCtrl
);

   import controlPkg::*;

   logic aluGroup;   // Flag writing ALU and immediate ops

   function automatic aluFunction_t aluFunctionOf(input opcode_t op);
      case (op)
         ADD, ADDI, ADDIB:            return FnADD;
         ADC, ADCI, SUC, SUCI:        return FnADC;   // Carry path serves both
         SUB, SUBI, SUBIB, CMP, CMPI: return FnSUB;
         NEG:                         return FnNEG;
         AND:                         return FnAND;
         OR:                          return FnOR;
         XOR:                         return FnXOR;
         NOT:                         return FnNOT;
         NAND:                        return FnNAND;
         NOR:                         return FnNOR;
         LSL:                         return FnLSL;
         LSR:                         return FnLSR;
         ASR:                         return FnASR;
         LUI:                         return FnLUI;
         LLI:                         return FnLLI;
         default:                     return FnA;
      endcase
   endfunction

   always_comb begin
      Class    = ClassSingle;
      aluGroup = 1'b0;
      case (Opcode)
         LDW: Class = ClassLoad;
         STW: Class = ClassStore;
         ADD, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB, SUC, SUCI, NEG, CMP, CMPI,
         AND, OR, XOR, NOT, NAND, NOR, LSL, LSR, ASR: aluGroup = 1'b1;
         default: ;
      endcase
   end

   always_comb begin
      DatapathCtrl = DatapathIdle;
      StatusWe     = 1'b0;
      if (Phase == Fetch) begin
         case (SubCycle)
            Cycle0: DatapathCtrl.pcEn = 1'b1;   // PC out as fetch address
            Cycle3: DatapathCtrl.irWe = 1'b1;
            default: ;
         endcase
      end else begin
         case (SubCycle)
            Cycle0: begin
               case (Opcode)
                  ADD, ADC, SUB, SUC, CMP, AND, OR, XOR, NAND, NOR:
                     DatapathCtrl.op2Sel = Op2Rd2;
                  ADDI, ADCI, SUBI, SUCI, CMPI, LSL, LSR, ASR:
                     DatapathCtrl.immSel = ImmShort;
                  ADDIB, SUBIB: DatapathCtrl.rs1Sel = Rs1Rd;   // Byte immediate into Rd
                  NEG, NOT:     DatapathCtrl.op2Sel = Op2Zero;
                  LUI, LLI: begin
                     DatapathCtrl.aluOp  = aluFunctionOf(Opcode);
                     DatapathCtrl.rs1Sel = Rs1Rd;
                     DatapathCtrl.aluEn  = 1'b1;
                     DatapathCtrl.regWe  = 1'b1;
                     DatapathCtrl.pcWe   = 1'b1;
                  end
                  LDW, STW: begin                               // Effective address
                     DatapathCtrl.aluOp  = FnADD;
                     DatapathCtrl.immSel = ImmShort;
                     DatapathCtrl.aluEn  = 1'b1;
                     DatapathCtrl.aluWe  = 1'b1;
                  end
                  BRANCH: begin
                     DatapathCtrl.pcWe = 1'b1;
                     case (BranchCode)
                        RET: begin
                           DatapathCtrl.lrEn  = 1'b1;
                           DatapathCtrl.pcSel = PcSysbus;
                        end
                        JMP: begin
                           DatapathCtrl.aluOp  = FnADD;
                           DatapathCtrl.immSel = ImmShort;
                           DatapathCtrl.pcSel  = PcAluOut;
                        end
                        default: begin                          // PC relative
                           DatapathCtrl.aluOp  = FnADD;
                           DatapathCtrl.op1Sel = Op1Pc;
                           DatapathCtrl.aluEn  = 1'b1;
                           if (BranchTaken) begin
                              DatapathCtrl.pcSel = PcAluOut;
                              if (BranchCode == BWL) begin
                                 DatapathCtrl.lrWe  = 1'b1;
                                 DatapathCtrl.lrSel = LrPc;
                              end
                           end
                        end
                     endcase
                  end
                  default: ;
               endcase
               if (aluGroup) begin
                  DatapathCtrl.aluOp = aluFunctionOf(Opcode);
                  DatapathCtrl.regWe = !(Opcode == CMP || Opcode == CMPI);
                  DatapathCtrl.pcWe  = 1'b1;
                  DatapathCtrl.pcEn  = 1'b1;
                  StatusWe           = 1'b1;
               end
            end
            Cycle1: begin                                       // Address held for ale
               DatapathCtrl.aluOp  = FnADD;
               DatapathCtrl.immSel = ImmShort;
               DatapathCtrl.aluEn  = 1'b1;
            end
            Cycle2: begin
               if (Class == ClassStore) begin                   // Latch store data
                  DatapathCtrl.aluOp  = FnADD;
                  DatapathCtrl.op2Sel = Op2Zero;
                  DatapathCtrl.rs1Sel = Rs1Rd;
                  DatapathCtrl.aluWe  = 1'b1;
                  DatapathCtrl.aluEn  = 1'b1;
               end
            end
            Cycle3: begin
               if (Class == ClassStore) begin
                  DatapathCtrl.aluOp  = FnADD;
                  DatapathCtrl.op2Sel = Op2Zero;
                  DatapathCtrl.aluEn  = 1'b1;
               end
            end
            default: begin
               DatapathCtrl.pcWe = 1'b1;                        // Step to next instruction
               if (Class == ClassLoad) begin
                  DatapathCtrl.wdSel = WdSys;
                  DatapathCtrl.regWe = 1'b1;
               end else begin
                  DatapathCtrl.aluOp  = FnADD;
                  DatapathCtrl.op2Sel = Op2Zero;
                  DatapathCtrl.aluEn  = 1'b1;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hdl/flagUnit.sv ====
// Status register and branch conditions
`timescale 1ns/1ps
`default_nettype none

module flagUnit (
   input  wire                     Clock,
   input  wire                     nReset,
   input  controlPkg::flags_t      Flags,
   input  logic                    StatusWe,
   input  controlPkg::branchCode_t BranchCode,
   output controlPkg::flags_t      StatusReg,
   output logic                    CFlag,
   output logic                    BranchTaken
);

   import controlPkg::*;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         StatusReg <= '0;
      end else if (StatusWe) begin
         StatusReg <= Flags;   // Only raised in Execute Cycle0
      end
   end

   assign CFlag = StatusReg[FlagC];

   always_comb begin
      case (BranchCode)
         BR, BWL, JMP: BranchTaken = 1'b1;
         BNE:          BranchTaken = !StatusReg[FlagZ];
         BE:           BranchTaken = StatusReg[FlagZ];
         BLT:          BranchTaken = StatusReg[FlagN] ^ StatusReg[FlagV];
         BGE:          BranchTaken = !(StatusReg[FlagN] ^ StatusReg[FlagV]);
         default:      BranchTaken = 1'b0;   // RET has its own PC source
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/busCycleGenerator.sv ====
// Memory bus strobe generator
`timescale 1ns/1ps
`default_nettype none

module busCycleGenerator (
   input  controlPkg::majorPhase_t Phase,
   input  controlPkg::subCycle_t   SubCycle,
   input  controlPkg::instrClass_t Class,
   output controlPkg::busCtrl_t    BusCtrl
);

   import controlPkg::*;

   always_comb begin
      BusCtrl = BusIdle;
      if (Phase == Fetch) begin
         case (SubCycle)
            Cycle0: begin                   // Address phase
               BusCtrl.ale = 1'b1;
               BusCtrl.nWe = 1'b1;
               BusCtrl.nOe = 1'b1;
            end
            Cycle1: begin
               BusCtrl.nMe   = 1'b0;
               BusCtrl.nWe   = 1'b1;
               BusCtrl.memEn = 1'b1;
            end
            Cycle2: begin                   // Opcode on the pads
               BusCtrl.nMe   = 1'b0;
               BusCtrl.nWe   = 1'b1;
               BusCtrl.memEn = 1'b1;
               BusCtrl.enb   = 1'b1;
            end
            default: begin
               BusCtrl.nWe   = 1'b1;
               BusCtrl.memEn = 1'b1;
            end
         endcase
      end else if (Class != ClassSingle) begin
         case (SubCycle)
            Cycle1: begin
               BusCtrl.ale = 1'b1;
               BusCtrl.nWe = 1'b1;
               BusCtrl.nOe = 1'b1;
            end
            Cycle2: begin
               BusCtrl.nMe   = 1'b0;
               BusCtrl.nOe   = 1'b1;
               BusCtrl.nWe   = 1'b1;
               BusCtrl.memEn = (Class == ClassLoad);
            end
            Cycle3: begin
               BusCtrl.nMe = 1'b0;
               if (Class == ClassLoad) begin
                  BusCtrl.nWe   = 1'b1;
                  BusCtrl.memEn = 1'b1;
                  BusCtrl.enb   = 1'b1;   // Read data in
               end else begin
                  BusCtrl.nOe = 1'b1;     // Write strobe, nWe low
               end
            end
            Cycle4: begin                 // Release, nMe back high
               if (Class == ClassLoad) begin
                  BusCtrl.nWe   = 1'b1;
                  BusCtrl.memEn = 1'b1;
               end else begin
                  BusCtrl.nOe = 1'b1;
               end
            end
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hdl/controlUnit.sv ====
// Multicycle processor control unit
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
   input  wire                       Clock,
   input  wire                       nReset,
   input  controlPkg::instrField_t   InstrIn,
   input  controlPkg::flags_t        Flags,
   input  logic                      nWait,
   output controlPkg::datapathCtrl_t DatapathCtrl,
   output controlPkg::busCtrl_t      BusCtrl,
   output controlPkg::flags_t        StatusReg,
   output logic                      CFlag
);

   import controlPkg::*;

   opcode_t     opcode;
   branchCode_t branchCode;
   majorPhase_t phase;
   subCycle_t   subCycle;
   instrClass_t instrClass;
   logic        statusWe;
   logic        branchTaken;

   // Opcode in the upper bits, condition below
   assign opcode     = opcode_t'(InstrIn[CondWidth +: OpcodeWidth]);
   assign branchCode = branchCode_t'(InstrIn[CondWidth-1:0]);

   phaseSequencer i_phaseSequencer (
      .Clock    (Clock),
      .nReset   (nReset),
      .Class    (instrClass),
      .nWait    (nWait),
      .Phase    (phase),
      .SubCycle (subCycle)
   );

   instructionDecoder i_instructionDecoder (
      .Opcode       (opcode),
      .BranchCode   (branchCode),
      .Phase        (phase),
      .SubCycle     (subCycle),
      .BranchTaken  (branchTaken),
      .Class        (instrClass),
      .StatusWe     (statusWe),
      .DatapathCtrl (DatapathCtrl)
   );

   flagUnit i_flagUnit (
      .Clock       (Clock),
      .nReset      (nReset),
      .Flags       (Flags),
      .StatusWe    (statusWe),
      .BranchCode  (branchCode),
      .StatusReg   (StatusReg),
      .CFlag       (CFlag),
      .BranchTaken (branchTaken)
   );

   busCycleGenerator i_busCycleGenerator (
      .Phase    (phase),
      .SubCycle (subCycle),
      .Class    (instrClass),
      .BusCtrl  (BusCtrl)
   );

endmodule

`default_nettype wire

// ==== bench/controlUnit_properties.sv ====
// Bus strobe assertions
`timescale 1ns/1ps
`default_nettype none

module controlUnit_properties (
   input wire                     Clock,
   input wire                     nReset,
   input controlPkg::majorPhase_t Phase,
   input controlPkg::subCycle_t   SubCycle,
   input controlPkg::busCtrl_t    BusCtrl
);

   import controlPkg::*;

   // Fetch opens the memory one cycle earlier than a data access
   nMeWindow: assert property (@(posedge Clock) disable iff (!nReset)
      !BusCtrl.nMe |-> (SubCycle == Cycle2 || SubCycle == Cycle3
                        || (Phase == Fetch && SubCycle == Cycle1)))
      else $error("nMe active outside its bus cycle window");

   aleApart: assert property (@(posedge Clock) disable iff (!nReset)
      !(BusCtrl.ale && !BusCtrl.nMe))
      else $error("ale and nMe active together");

   enbRead: assert property (@(posedge Clock) disable iff (!nReset)
      BusCtrl.enb |-> !BusCtrl.nOe)
      else $error("enb with nOe high");

endmodule

bind controlUnit controlUnit_properties i_properties (
   .Clock(Clock), .nReset(nReset), .Phase(phase), .SubCycle(subCycle), .BusCtrl(BusCtrl)
);

`default_nettype wire

// ==== bench/controlUnitChecker.sv ====
// Control unit reference checker
`timescale 1ns/1ps
`default_nettype none

module controlUnitChecker (
   input  wire                       Clock,
   input  wire                       nReset,
   input  controlPkg::instrField_t   InstrIn,
   input  controlPkg::flags_t        Flags,
   input  logic                      nWait,
   input  controlPkg::datapathCtrl_t DatapathCtrl,
   input  controlPkg::busCtrl_t      BusCtrl,
   input  controlPkg::flags_t        StatusReg,
   input  logic                      CFlag,
   output int                        ErrorCount,
   output int                        CheckCount
);

   import controlPkg::*;

   majorPhase_t phase;         // Expected phase tracked from the ports
   subCycle_t   sub;
   flags_t      statusModel;
   opcode_t     opcode;
   branchCode_t cond;
   int          errors = 0;
   int          checks = 0;

   assign opcode     = opcode_t'(InstrIn[7:3]);
   assign cond       = branchCode_t'(InstrIn[2:0]);
   assign ErrorCount = errors;
   assign CheckCount = checks;

   function automatic logic flagWriter(input opcode_t op);
      case (op)
         ADD, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB, SUC, SUCI, NEG, CMP, CMPI,
         AND, OR, XOR, NOT, NAND, NOR, LSL, LSR, ASR: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic aluFunction_t aluFnFor(input opcode_t op);
      case (op)
         ADD, ADDI, ADDIB:            return FnADD;
         ADC, ADCI, SUC, SUCI:        return FnADC;
         SUB, SUBI, SUBIB, CMP, CMPI: return FnSUB;
         NEG:  return FnNEG;
         AND:  return FnAND;
         OR:   return FnOR;
         XOR:  return FnXOR;
         NOT:  return FnNOT;
         NAND: return FnNAND;
         NOR:  return FnNOR;
         LSL:  return FnLSL;
         LSR:  return FnLSR;
         ASR:  return FnASR;
         LUI:  return FnLUI;
         LLI:  return FnLLI;
         default: return FnA;
      endcase
   endfunction

   function automatic logic takenFor(input branchCode_t code, input flags_t st);
      case (code)
         BNE:     return !st[FlagZ];
         BE:      return st[FlagZ];
         BLT:     return st[FlagN] != st[FlagV];
         BGE:     return st[FlagN] == st[FlagV];
         RET:     return 1'b0;
         default: return 1'b1;   // BR, BWL, JMP
      endcase
   endfunction

   function automatic datapathCtrl_t expectedCtrl(input opcode_t op, input branchCode_t code,
                                                  input flags_t st, input majorPhase_t ph,
                                                  input subCycle_t sc);
      datapathCtrl_t e;
      e = '0;
      if (ph == Fetch) begin
         if (sc == Cycle0) e.pcEn = 1'b1;
         if (sc == Cycle3) e.irWe = 1'b1;
      end else if (sc == Cycle0) begin
         if (flagWriter(op)) begin
            e.aluOp = aluFnFor(op);
            e.regWe = !(op == CMP || op == CMPI);
            e.pcWe  = 1'b1;
            e.pcEn  = 1'b1;
         end else if (op == LUI || op == LLI) begin
            e.aluOp = aluFnFor(op);
            e.regWe = 1'b1;
            e.pcWe  = 1'b1;
         end else if (op == BRANCH) begin
            e.pcWe = 1'b1;
            if (code == RET) begin
               e.pcSel = PcSysbus;
               e.lrEn  = 1'b1;
            end else if (takenFor(code, st)) begin
               e.pcSel = PcAluOut;
            end
            if (code == BWL) begin   // Link on call
               e.lrWe  = 1'b1;
               e.lrSel = LrPc;
            end
         end
      end else if (sc == Cycle4) begin
         e.pcWe = 1'b1;
         if (op == LDW) begin
            e.wdSel = WdSys;
            e.regWe = 1'b1;
         end
      end
      return e;
   endfunction

   function automatic busCtrl_t expectedBus(input opcode_t op, input majorPhase_t ph,
                                            input subCycle_t sc);
      busCtrl_t b;
      b = '{ale: 1'b0, nMe: 1'b1, nOe: 1'b0, nWe: 1'b0, enb: 1'b0, memEn: 1'b0};
      if (ph == Fetch || op == LDW || op == STW) begin
         if ((ph == Fetch && sc == Cycle0) || (ph == Execute && sc == Cycle1)) begin
            b.ale = 1'b1;   // Address phase
            b.nWe = 1'b1;
            b.nOe = 1'b1;
         end else if (ph == Fetch || op == LDW) begin
            b.nMe   = !((ph == Fetch && (sc == Cycle1 || sc == Cycle2))
                        || (ph == Execute && (sc == Cycle2 || sc == Cycle3)));
            b.nWe   = 1'b1;
            b.memEn = 1'b1;
            b.enb   = (ph == Fetch && sc == Cycle2) || (ph == Execute && sc == Cycle3);
            b.nOe   = (ph == Execute && sc == Cycle2);
            if (ph == Execute && sc == Cycle0) b = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
         end else if (sc != Cycle0) begin
            b.nMe = !(sc == Cycle2 || sc == Cycle3);
            b.nOe = 1'b1;
            b.nWe = (sc == Cycle2);   // Write strobe in Cycle3
         end
      end
      return b;
   endfunction

   function automatic logic ctrlMatches(input datapathCtrl_t a, input datapathCtrl_t e,
                                        input opcode_t op, input majorPhase_t ph,
                                        input subCycle_t sc);
      logic ok;
      ok = a.pcSel == e.pcSel && a.wdSel == e.wdSel && a.regWe == e.regWe
           && a.pcWe == e.pcWe && a.pcEn == e.pcEn && a.irWe == e.irWe
           && a.lrEn == e.lrEn && a.lrWe == e.lrWe;
      if (ph == Fetch)
         ok = ok && a.aluWe == e.aluWe;
      if (ph == Execute && sc == Cycle0 && (flagWriter(op) || op == LUI || op == LLI))
         ok = ok && a.aluOp == e.aluOp;
      if (ph == Execute && sc == Cycle0 && op == BRANCH)
         ok = ok && a.lrSel == e.lrSel;
      return ok;
   endfunction

   always @(posedge Clock) begin : compare
      datapathCtrl_t ctrlExp;
      busCtrl_t      busExp;
      ctrlExp = expectedCtrl(opcode, cond, statusModel, phase, sub);
      busExp  = expectedBus(opcode, phase, sub);
      checks++;
      if (!ctrlMatches(DatapathCtrl, ctrlExp, opcode, phase, sub)) begin
         errors++;
         $display("FAIL %s %s %s control: expected %h actual %h", opcode.name(),
                  phase.name(), sub.name(), ctrlExp, DatapathCtrl);
      end
      if (BusCtrl !== busExp) begin
         errors++;
         $display("FAIL %s %s %s strobes: expected %b actual %b", opcode.name(),
                  phase.name(), sub.name(), busExp, BusCtrl);
      end
      if (StatusReg !== statusModel || CFlag !== statusModel[FlagC]) begin
         errors++;
         $display("FAIL %s status: expected %b actual %b carry %b", opcode.name(),
                  statusModel, StatusReg, CFlag);
      end
   end

   // Expected sequencing
   always @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         phase       <= Fetch;
         sub         <= Cycle0;
         statusModel <= '0;
      end else if (phase == Fetch) begin
         if (sub == Cycle0) sub <= Cycle1;
         else if (sub == Cycle1) sub <= Cycle2;
         else if (sub == Cycle2) begin
            if (nWait) sub <= Cycle3;
         end else begin
            phase <= Execute;
            sub   <= Cycle0;
         end
      end else begin
         case (sub)
            Cycle0: begin
               if (flagWriter(opcode)) statusModel <= Flags;
               if (opcode == LDW || opcode == STW) sub <= Cycle1;
               else phase <= Fetch;
            end
            Cycle1: sub <= Cycle2;
            Cycle2: sub <= Cycle3;
            Cycle3: if (nWait) sub <= Cycle4;
            default: begin
               phase <= Fetch;
               sub   <= Cycle0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== bench/controlUnitTb.sv ====
// Control unit testbench
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;

   import controlPkg::*;

   logic          Clock;
   logic          nReset;
   instrField_t   InstrIn;
   flags_t        Flags;
   logic          nWait;
   datapathCtrl_t DatapathCtrl;
   busCtrl_t      BusCtrl;
   flags_t        StatusReg;
   logic          CFlag;
   int            errorCount;
   int            checkCount;
   integer        seed;
   int            waitLeft;
   int            testsPassed;
   int            testsFailed;
   int            errorsBefore;
   logic          timedOut;
   opcode_t       aluOps[24];

   controlUnit i_controlUnit (
      .Clock(Clock), .nReset(nReset), .InstrIn(InstrIn), .Flags(Flags), .nWait(nWait),
      .DatapathCtrl(DatapathCtrl), .BusCtrl(BusCtrl), .StatusReg(StatusReg), .CFlag(CFlag)
   );

   controlUnitChecker i_checker (
      .Clock(Clock), .nReset(nReset), .InstrIn(InstrIn), .Flags(Flags), .nWait(nWait),
      .DatapathCtrl(DatapathCtrl), .BusCtrl(BusCtrl), .StatusReg(StatusReg), .CFlag(CFlag),
      .ErrorCount(errorCount), .CheckCount(checkCount)
   );

   initial begin
      Clock = 1'b0;
      forever #4 Clock = ~Clock;
   end

   // One falling edge with random wait bursts of up to 3 cycles
   task automatic stepCycle;
      logic [31:0] r;
      @(negedge Clock);
      r = $random(seed);
      if (waitLeft > 0) begin
         nWait = 1'b0;
         waitLeft--;
      end else begin
         nWait = 1'b1;
         if (r[3:2] == 2'b00) waitLeft = int'(r[5:4]);
      end
   endtask

   task automatic awaitFetchStart;
      int n;
      n = 0;
      while (!(BusCtrl.ale && DatapathCtrl.pcEn) && n < 40) begin
         stepCycle();
         n++;
      end
      if (!(BusCtrl.ale && DatapathCtrl.pcEn)) begin
         timedOut = 1'b1;
         $display("Timeout: the DUT never returned to the fetch address cycle");
      end
   endtask

   task automatic runInstr(input opcode_t op, input logic [2:0] cond, input flags_t fl);
      int n;
      if (timedOut) return;
      awaitFetchStart();
      if (timedOut) return;
      InstrIn = {op, cond};   // Held for the whole instruction
      Flags   = fl;
      stepCycle();
      n = 0;
      while (!DatapathCtrl.irWe && n < 40) begin
         stepCycle();
         n++;
      end
      if (!DatapathCtrl.irWe) begin
         timedOut = 1'b1;
         $display("Timeout: irWe never rose during the fetch");
      end
   endtask

   task automatic runRandom(input opcode_t op);
      logic [31:0] r;
      r = $random(seed);
      runInstr(op, r[2:0], r[7:4]);
   endtask

   task automatic endTest(input string name);
      awaitFetchStart();
      if (errorCount == errorsBefore && !timedOut) begin
         testsPassed++;
         $display("%s: passed", name);
      end else begin
         testsFailed++;
         $display("%s: failed with %0d mismatches", name, errorCount - errorsBefore);
      end
      errorsBefore = errorCount;
   endtask

   initial begin
      logic [31:0] r;
      seed         = 32'h9932_2b03;
      nReset       = 1'b0;
      InstrIn      = {ADD, 3'b000};
      Flags        = '0;
      nWait        = 1'b1;
      waitLeft     = 0;
      testsPassed  = 0;
      testsFailed  = 0;
      errorsBefore = 0;
      timedOut     = 1'b0;
      aluOps = '{ADD, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB, SUC, SUCI, NEG, CMP,
                 CMPI, AND, OR, XOR, NOT, NAND, NOR, LSL, LSR, ASR, LUI, LLI};
      repeat (8) @(negedge Clock);
      nReset = 1'b1;

      repeat (4) runRandom(ADD);
      endTest("reset and fetch");

      foreach (aluOps[i]) runRandom(aluOps[i]);
      endTest("alu operations");

      runInstr(ADD, 3'd0, 4'b1010);
      runInstr(LUI, 3'd0, 4'b0101);   // Must not touch the status
      runInstr(CMP, 3'd0, 4'b0111);
      runInstr(LLI, 3'd0, 4'b1111);
      endTest("status register");

      for (int c = 0; c < 8; c++) begin
         for (int f = 0; f < 16; f++) begin
            r = $random(seed);
            runInstr(SUB, 3'd0, f[3:0]);
            runInstr(BRANCH, c[2:0], r[3:0]);
         end
      end
      endTest("branches");

      repeat (12) runRandom(LDW);
      endTest("load bus cycle");

      repeat (12) runRandom(STW);
      endTest("store bus cycle");

      $display("Tests passed %0d, failed %0d, checks %0d, mismatches %0d",
               testsPassed, testsFailed, checkCount, errorCount);
      if (timedOut || testsFailed > 0 || errorCount > 0) begin
         $display(">>> FAIL");
      end else begin
         $display(">>> PASS");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/controlPkg.sv
hdl/phaseSequencer.sv
hdl/instructionDecoder.sv
hdl/flagUnit.sv
hdl/busCycleGenerator.sv
hdl/controlUnit.sv
bench/controlUnit_properties.sv
bench/controlUnitChecker.sv
bench/controlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the control unit simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module controlUnitTb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/VcontrolUnitTb)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx '>>> PASS'; then
   exit 0
else
   exit 1
fi
